// ==== rtl/alien_formation_defs.svh ====
// Alien formation constants

`ifndef ALIEN_FORMATION_DEFS_SVH
`define ALIEN_FORMATION_DEFS_SVH

// Screen and sprite geometry
`define COORD_W         12
`define SPRITE_SIZE     16
`define SLOT_PITCH      32
`define NUM_SLOTS       5

// Power-up position of the formation
`define START_ROW       20
`define START_COL       244

// March rules
`define STEP_COLS       12
`define DROP_ROWS       24
`define LEFT_EDGE       21
`define RIGHT_EDGE      500
`define LOSE_ROW        360
`define MOTION_TICKS    16000000

`define PIXEL_ON        15

`endif

// ==== rtl/alien_formation_pkg.sv ====
// Alien formation types

`include "alien_formation_defs.svh"

package alien_formation_pkg;

    // Screen row or column
    typedef logic [`COORD_W-1:0] coord_t;

    // Pixel intensity
    typedef logic [3:0] pixel_t;

    // One bit per alien, bit 0 is the leftmost
    typedef logic [`NUM_SLOTS-1:0] slot_mask_t;

    // Offset inside one sprite
    typedef logic [$clog2(`SPRITE_SIZE)-1:0] local_t;

    typedef enum logic
    {
        MARCH_RIGHT = 1'b0,
        MARCH_LEFT  = 1'b1
    } march_dir_t;

endpackage

// ==== rtl/alien_march_ctrl.sv ====
// Formation march controller

`include "alien_formation_defs.svh"

module alien_march_ctrl
    import alien_formation_pkg::*;
#(
    parameter int unsigned step_ticks = `MOTION_TICKS
)
(
    input  logic   clk,
    input  logic   arst_n,
    output coord_t sprite_row,
    output coord_t sprite_column,
    output logic   lose
);

    localparam int CNT_W = (step_ticks > 1) ? $clog2(step_ticks) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             step;

    march_dir_t dir_q;
    march_dir_t dir_next;
    coord_t     row_q;
    coord_t     row_next;
    coord_t     col_q;
    coord_t     col_next;

    // Step on the last cycle of each period
    assign step = (tick_cnt == CNT_W'(step_ticks - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            tick_cnt <= '0;
        else if (step)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // Drop and turn at an edge, otherwise slide one step
    always_comb
    begin
        row_next = row_q;
        col_next = col_q;
        dir_next = dir_q;
        if (dir_q == MARCH_LEFT)
        begin
            if (col_q < coord_t'(`LEFT_EDGE))
            begin
                row_next = row_q + coord_t'(`DROP_ROWS);
                dir_next = MARCH_RIGHT;
            end
            else
                col_next = col_q - coord_t'(`STEP_COLS);
        end
        else
        begin
            if (col_q > coord_t'(`RIGHT_EDGE))
            begin
                row_next = row_q + coord_t'(`DROP_ROWS);
                dir_next = MARCH_LEFT;
            end
            else
                col_next = col_q + coord_t'(`STEP_COLS);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            row_q <= coord_t'(`START_ROW);
            col_q <= coord_t'(`START_COL);
            dir_q <= MARCH_RIGHT;
        end
        else if (step)
        begin
            row_q <= row_next;
            col_q <= col_next;
            dir_q <= dir_next;
        end
    end

    assign sprite_row    = row_q;
    assign sprite_column = col_q;
    assign lose          = (row_q > coord_t'(`LOSE_ROW));

    // Edge turns keep the formation within one step of either edge
    assert property (@(posedge clk) disable iff (!arst_n)
        (col_q >= coord_t'(`LEFT_EDGE - `STEP_COLS)) &&
        (col_q <= coord_t'(`RIGHT_EDGE + `STEP_COLS)));

    // The formation only ever moves down
    assert property (@(posedge clk) disable iff (!arst_n)
        row_q >= $past(row_q));

endmodule

// ==== rtl/formation_locator.sv ====
// Pixel to alien slot locator

`include "alien_formation_defs.svh"

module formation_locator
    import alien_formation_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  coord_t     pixel_row,
    input  coord_t     pixel_column,
    input  coord_t     sprite_row,
    input  coord_t     sprite_column,
    output slot_mask_t hit_mask,
    output local_t     local_row,
    output local_t     local_col
);

    coord_t     row_base;
    coord_t     col_base;
    logic       row_in;
    slot_mask_t hit_d;
    local_t     local_col_d;

    // Sprite position sits one pixel above and left of the first lit row/column.
    // Offsets left of the sprite wrap to large values and fall outside.
    assign row_base = pixel_row - sprite_row - 1'b1;
    assign col_base = pixel_column - sprite_column - 1'b1;
    assign row_in   = (row_base < coord_t'(`SPRITE_SIZE));

    // Windows are disjoint, so at most one slot matches
    always_comb
    begin
        coord_t slot_off;
        hit_d       = '0;
        local_col_d = '0;
        for (int k = 0; k < `NUM_SLOTS; k++)
        begin
            slot_off = col_base - coord_t'(k * `SLOT_PITCH);
            if (row_in && (slot_off < coord_t'(`SPRITE_SIZE)))
            begin
                hit_d[k]    = 1'b1;
                local_col_d = local_t'(slot_off);
            end
        end
    end

    // Mask and local offsets of the matching slot
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit_mask  <= '0;
            local_row <= '0;
            local_col <= '0;
        end
        else
        begin
            hit_mask  <= hit_d;
            local_row <= local_t'(row_base);
            local_col <= local_col_d;
        end
    end

    // Slot pitch leaves a gap between sprites, no pixel hits two aliens
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(hit_mask));

endmodule

// ==== rtl/alien_sprite_rom.sv ====
// Alien bitmap lookup

`include "alien_formation_defs.svh"

module alien_sprite_rom
    import alien_formation_pkg::*;
(
    input  slot_mask_t hit_mask,
    input  local_t     local_row,
    input  local_t     local_col,
    output pixel_t     alien_pixel
);

    localparam int BAND_W = $bits(local_t) - 1;

    logic [BAND_W-1:0]      band;
    logic [`SPRITE_SIZE-1:0] band_bits;

    // Each pattern covers two rows, bit n is local column n
    function automatic logic [`SPRITE_SIZE-1:0] band_pattern(
        input logic [BAND_W-1:0] idx
    );
        logic [`SPRITE_SIZE-1:0] bits;
        case (idx)
            3'd0:    bits = 16'h03C0;
            3'd1:    bits = 16'h0FF0;
            3'd2:    bits = 16'h3FFC;
            // Eyes cut out of the head
            3'd3:    bits = 16'hF3CF;
            3'd4:    bits = 16'hFFFF;
            3'd5:    bits = 16'h0C30;
            3'd6:    bits = 16'h33CC;
            // Legs
            3'd7:    bits = 16'hCC33;
            default: bits = '0;
        endcase
        return bits;
    endfunction

    assign band      = local_row[$bits(local_t)-1:1];
    assign band_bits = band_pattern(band);

    // Dark outside every window
    always_comb
    begin
        if ((|hit_mask) && band_bits[local_col])
            alien_pixel = pixel_t'(`PIXEL_ON);
        else
            alien_pixel = '0;
    end

endmodule

// ==== rtl/alien_formation.sv ====
// Alien formation renderer top

`include "alien_formation_defs.svh"

module alien_formation
    import alien_formation_pkg::*;
#(
    parameter int unsigned step_ticks = `MOTION_TICKS
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  coord_t     pixel_row,
    input  coord_t     pixel_column,
    output pixel_t     alien_pixel,
    output slot_mask_t slot_active,
    output logic       lose
);

    coord_t     sprite_row;
    coord_t     sprite_column;
    slot_mask_t hit_mask;
    local_t     local_row;
    local_t     local_col;

    alien_march_ctrl #(
        .step_ticks   (step_ticks)
    ) u_march_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .sprite_row   (sprite_row),
        .sprite_column(sprite_column),
        .lose         (lose)
    );

    formation_locator u_locator (
        .clk          (clk),
        .arst_n       (arst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .sprite_row   (sprite_row),
        .sprite_column(sprite_column),
        .hit_mask     (hit_mask),
        .local_row    (local_row),
        .local_col    (local_col)
    );

    // Registered mask doubles as the slot output
    assign slot_active = hit_mask;

    alien_sprite_rom u_sprite_rom (
        .hit_mask     (hit_mask),
        .local_row    (local_row),
        .local_col    (local_col),
        .alien_pixel  (alien_pixel)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
// Testbench clock source

module tb_clock_gen
#(
    parameter int period = 20
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~clk;
    end

endmodule

// ==== test/alien_formation_tb.sv ====
// Alien formation testbench

module alien_formation_tb
    import alien_formation_pkg::*;
();

    localparam int    CLK_PERIOD  = 20;
    localparam int    DRIVE_DELAY = 2;
    localparam int    STEP_TICKS  = 40;
    localparam int    WATCH_SLACK = 100;
    localparam string INPUT_FILE  = "test/alien_formation_input.txt";

    logic       clk;
    logic       arst_n;
    coord_t     pixel_row;
    coord_t     pixel_column;
    pixel_t     alien_pixel;
    slot_mask_t slot_active;
    logic       lose;

    // Query vectors from the input file
    int         vec_cycle[$];
    coord_t     vec_row[$];
    coord_t     vec_col[$];
    pixel_t     vec_pixel[$];
    slot_mask_t vec_mask[$];
    logic       vec_lose[$];

    int   num_vectors = 0;
    int   cycle_count = 0;
    logic loaded      = 1'b0;

    tb_clock_gen #(
        .period       (CLK_PERIOD)
    ) u_clock (
        .clk          (clk)
    );

    alien_formation #(
        .step_ticks   (STEP_TICKS)
    ) UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .alien_pixel  (alien_pixel),
        .slot_active  (slot_active),
        .lose         (lose)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string what);
        $display("Error at time %0t: %s", $time, what);
        abort_run("Stopping at the first mismatch");
    endtask

    task automatic check_pixel(input pixel_t actual, input pixel_t expected, input int query);
        if (actual !== expected)
            report_mismatch($sformatf("alien_pixel is %0d, expected %0d (query cycle %0d)",
                                      actual, expected, query));
    endtask

    task automatic check_mask(input slot_mask_t actual, input slot_mask_t expected,
                              input int query);
        if (actual !== expected)
            report_mismatch($sformatf("slot_active is %b, expected %b (query cycle %0d)",
                                      actual, expected, query));
    endtask

    task automatic check_lose(input logic actual, input logic expected, input int query);
        if (actual !== expected)
            report_mismatch($sformatf("lose is %b, expected %b (query cycle %0d)",
                                      actual, expected, query));
    endtask

    task automatic load_vectors();
        int         fd;
        int         fields;
        int         line_no;
        int         q_cycle;
        int         q_row;
        int         q_col;
        int         q_pixel;
        int         q_lose;
        slot_mask_t q_mask;
        string      line;
        string      problem;
        problem = "";
        line_no = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0)
            problem = {"Cannot open the vector file ", INPUT_FILE};
        else
        begin
            while ((problem == "") && ($fgets(line, fd) != 0))
            begin
                line_no++;
                // Skip blank lines and column notes
                if ((line.len() > 1) && (line[0] != "#"))
                begin
                    fields = $sscanf(line, "%d %d %d %d %b %d", q_cycle, q_row, q_col,
                                     q_pixel, q_mask, q_lose);
                    if (fields != 6)
                        problem = $sformatf("Line %0d of the vector file cannot be read",
                                            line_no);
                    else if ((vec_cycle.size() > 0) && (q_cycle <= vec_cycle[$]))
                        problem = $sformatf("Line %0d of the vector file is out of order",
                                            line_no);
                    else
                    begin
                        vec_cycle.push_back(q_cycle);
                        vec_row.push_back(coord_t'(q_row));
                        vec_col.push_back(coord_t'(q_col));
                        vec_pixel.push_back(pixel_t'(q_pixel));
                        vec_mask.push_back(q_mask);
                        vec_lose.push_back(q_lose != 0);
                    end
                end
            end
            $fclose(fd);
        end
        if ((problem == "") && (vec_cycle.size() == 0))
            problem = "The vector file holds no queries";
        if (problem != "")
            abort_run(problem);
        num_vectors = vec_cycle.size();
        loaded = 1'b1;
    endtask

    // Inputs change a short delay after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        cycle_count++;
    endtask

    // Pixel sampled one edge later, result checked before the following edge
    task automatic run_query(input int idx);
        while (cycle_count < vec_cycle[idx])
            next_cycle();
        pixel_row    = vec_row[idx];
        pixel_column = vec_col[idx];
        next_cycle();
        check_pixel(alien_pixel, vec_pixel[idx], vec_cycle[idx]);
        check_mask(slot_active, vec_mask[idx], vec_cycle[idx]);
        check_lose(lose, vec_lose[idx], vec_cycle[idx]);
    endtask

    initial
    begin
        arst_n       = 1'b0;
        pixel_row    = '0;
        pixel_column = '0;
        load_vectors();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        arst_n      = 1'b1;
        cycle_count = 0;
        for (int i = 0; i < num_vectors; i++)
            run_query(i);
        $display("*** PASSED ***");
        $finish;
    end

    // Run length follows the last query in the file
    initial
    begin
        wait (loaded);
        #((vec_cycle[num_vectors-1] + WATCH_SLACK) * CLK_PERIOD);
        abort_run("Timeout, the queries did not finish in time");
    end

endmodule

// ==== alien_formation.f ====
+incdir+rtl
rtl/alien_formation_pkg.sv
rtl/alien_march_ctrl.sv
rtl/formation_locator.sv
rtl/alien_sprite_rom.sv
rtl/alien_formation.sv
test/tb_clock_gen.sv
test/alien_formation_tb.sv

// ==== test/alien_formation_input.txt ====
# cycle row col pixel mask(binary, bit 0 = leftmost alien) lose
# cycle counts rising edges after reset release, the step period is 40
4 21 251 15 00001 0
5 21 250 0 00001 0
6 27 245 15 00001 0
7 27 249 0 00001 0
8 29 260 15 00001 0
9 36 259 15 00001 0
10 36 247 0 00001 0
11 31 249 15 00001 0
12 29 277 15 00010 0
13 21 309 0 00100 0
14 22 348 15 01000 0
15 30 388 15 10000 0
16 29 261 0 00000 0
17 29 276 0 00000 0
18 20 250 0 00000 0
19 37 250 0 00000 0
20 29 244 0 00000 0
21 29 389 0 00000 0
22 0 0 0 00000 0
220 21 311 15 00001 0
221 27 309 0 00001 0
222 29 384 15 00100 0
223 21 251 0 00000 0
420 36 365 15 00001 0
421 31 497 15 10000 0
900 29 509 15 00001 0
940 53 509 15 00001 0
941 29 509 0 00000 0
980 45 503 15 00001 0
2620 69 24 15 00001 0
2660 76 138 15 01000 0
22780 365 17 15 00001 0
24460 381 579 15 00100 1
